/* src/mshr_pkg.sv */
// MSHR shared definitions
// Sizes, vector types and the entry state encoding for the L1D miss
// handling block, plus the small one-hot helpers used by the pickers
`default_nettype none

package mshr_pkg;

  localparam int MSHR_ENTRIES  = 4;
  localparam int NUM_REQ_PORTS = 2;
  localparam int PADDR_W       = 32;
  localparam int LINE_BYTES    = 16;
  localparam int LINE_OFFSET_W = $clog2(LINE_BYTES);
  localparam int LINE_W        = LINE_BYTES * 8;
  localparam int ENTRY_IDX_W   = $clog2(MSHR_ENTRIES);

  // L2 tag layout is {source marker, zero filler, entry index}
  localparam int L2_TAG_W      = 8;
  localparam int L2_TAG_FILL_W = L2_TAG_W - 2 - ENTRY_IDX_W;
  localparam logic [1:0] L2_TAG_SRC_L1D = 2'b10;

  typedef logic [PADDR_W-1:0]       paddr_t;
  typedef logic [LINE_W-1:0]        line_t;
  typedef logic [MSHR_ENTRIES-1:0]  entry_oh_t;
  typedef logic [ENTRY_IDX_W-1:0]   entry_idx_t;
  typedef logic [NUM_REQ_PORTS-1:0] port_vec_t;
  typedef logic [L2_TAG_W-1:0]      l2_tag_t;

  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_WAIT_SEND = 2'd1,  // Allocated, L2 read not yet taken
    ST_WAIT_RESP = 2'd2,
    ST_WAIT_WR   = 2'd3   // Line captured, L1D write pending
  } mshr_state_e;

  // Lowest set bit of a vector over the entries
  function automatic entry_oh_t lowest_oh(entry_oh_t vec);
    return vec & (~vec + 1'b1);
  endfunction

  function automatic entry_idx_t oh_to_idx(entry_oh_t oh);
    entry_idx_t idx;
    idx = '0;
    for (int i = 0; i < MSHR_ENTRIES; i++) begin
      if (oh[i]) begin
        idx = idx | entry_idx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

/* src/mshr_alloc.sv */
// MSHR allocation stage
// Checks each load-miss port against the lines already held and against
// lower-numbered ports, merges matches onto the existing entry and hands
// the remaining requests the lowest free entries in port order
`timescale 1ns/1ns
`default_nettype none

module mshr_alloc import mshr_pkg::*; (
  input  wire port_vec_t  i_req_valid,
  input  wire paddr_t     i_req_paddr [NUM_REQ_PORTS],
  input  wire entry_oh_t  i_entry_valid,
  input  wire paddr_t     i_entry_paddr [MSHR_ENTRIES],

  output entry_oh_t       o_req_entry_oh [NUM_REQ_PORTS],
  output port_vec_t       o_req_full,
  output entry_oh_t       o_alloc,
  output paddr_t          o_alloc_paddr [MSHR_ENTRIES]
);

  // Line compare ignores the byte offset
  function automatic logic same_line(paddr_t a, paddr_t b);
    return a[PADDR_W-1:LINE_OFFSET_W] == b[PADDR_W-1:LINE_OFFSET_W];
  endfunction

  // ----------------------------------------
  // Conflict check and allocation
  // ----------------------------------------
  always_comb begin
    entry_oh_t w_free;
    entry_oh_t w_pick;
    entry_oh_t w_hit_entry;
    logic      w_port_hit;

    w_free  = ~i_entry_valid;
    o_alloc = '0;
    for (int e = 0; e < MSHR_ENTRIES; e++) begin
      o_alloc_paddr[e] = '0;
    end

    for (int p = 0; p < NUM_REQ_PORTS; p++) begin
      o_req_entry_oh[p] = '0;
      o_req_full[p]     = 1'b0;
      w_hit_entry       = '0;
      w_port_hit        = 1'b0;
      w_pick            = '0;

      if (i_req_valid[p]) begin
        // Line already held by a live entry
        for (int e = 0; e < MSHR_ENTRIES; e++) begin
          w_hit_entry[e] = i_entry_valid[e] & same_line(i_entry_paddr[e], i_req_paddr[p]);
        end

        if (|w_hit_entry) begin
          o_req_entry_oh[p] = w_hit_entry;
        end else begin
          // Same line as a lower port this cycle, follow its result
          for (int q = 0; q < p; q++) begin
            if (!w_port_hit && i_req_valid[q] && same_line(i_req_paddr[q], i_req_paddr[p])) begin
              w_port_hit        = 1'b1;
              o_req_entry_oh[p] = o_req_entry_oh[q];
              o_req_full[p]     = o_req_full[q];
            end
          end

          if (!w_port_hit) begin
            w_pick = lowest_oh(w_free);
            if (w_pick == '0) begin
              o_req_full[p] = 1'b1;  // No entry left, LSU retries
            end else begin
              o_req_entry_oh[p] = w_pick;
              o_alloc           = o_alloc | w_pick;
              w_free            = w_free & ~w_pick;
              for (int e = 0; e < MSHR_ENTRIES; e++) begin
                if (w_pick[e]) begin
                  o_alloc_paddr[e] = i_req_paddr[p];
                end
              end
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/mshr_entry_array.sv */
// MSHR entry array
// Holds the state, line address and line data of every miss entry.
// Each entry walks idle, wait-send, wait-response, wait-write and back
// to idle, driven by the strobes of the surrounding stages
`timescale 1ns/1ns
`default_nettype none

module mshr_entry_array import mshr_pkg::*; (
  input  wire logic      i_clk,
  input  wire logic      i_reset_n,

  input  wire entry_oh_t i_alloc,
  input  wire paddr_t    i_alloc_paddr [MSHR_ENTRIES],
  input  wire entry_oh_t i_sent,
  input  wire entry_oh_t i_fill,
  input  wire line_t     i_fill_data,
  input  wire entry_oh_t i_written,

  output entry_oh_t      o_entry_valid,
  output entry_oh_t      o_send_ready,
  output entry_oh_t      o_wr_ready,
  output paddr_t         o_entry_paddr [MSHR_ENTRIES],
  output line_t          o_entry_data [MSHR_ENTRIES]
);

  for (genvar e = 0; e < MSHR_ENTRIES; e++) begin : g_entry
    mshr_state_e r_state;
    mshr_state_e w_state_nxt;
    paddr_t      r_paddr;
    line_t       r_data;
    logic        w_take_alloc;
    logic        w_take_fill;

    assign w_take_alloc = (r_state == ST_IDLE) & i_alloc[e];
    assign w_take_fill  = (r_state == ST_WAIT_RESP) & i_fill[e];

    // ----------------------------------------
    // Entry FSM
    // ----------------------------------------
    always_comb begin
      w_state_nxt = r_state;
      case (r_state)
        ST_IDLE: begin
          if (i_alloc[e]) begin
            w_state_nxt = ST_WAIT_SEND;
          end
        end
        ST_WAIT_SEND: begin
          if (i_sent[e]) begin
            w_state_nxt = ST_WAIT_RESP;
          end
        end
        ST_WAIT_RESP: begin
          if (i_fill[e]) begin
            w_state_nxt = ST_WAIT_WR;
          end
        end
        ST_WAIT_WR: begin
          if (i_written[e]) begin
            w_state_nxt = ST_IDLE;  // Freed at the write handshake
          end
        end
        default: begin
          w_state_nxt = ST_IDLE;
        end
      endcase
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_state <= ST_IDLE;
      end else begin
        r_state <= w_state_nxt;
      end
    end

    // ----------------------------------------
    // Line address and data
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
      if (w_take_alloc) begin
        r_paddr <= {i_alloc_paddr[e][PADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
      end
      if (w_take_fill) begin
        r_data <= i_fill_data;
      end
    end

    assign o_entry_valid[e] = (r_state != ST_IDLE);
    assign o_send_ready[e]  = (r_state == ST_WAIT_SEND);
    assign o_wr_ready[e]    = (r_state == ST_WAIT_WR);
    assign o_entry_paddr[e] = r_paddr;
    assign o_entry_data[e]  = r_data;
  end

endmodule

`default_nettype wire

/* src/mshr_l2_issue.sv */
// MSHR L2 read issue
// Sends one line read per waiting entry to L2, lowest entry first.
// A request stalled by L2 keeps its entry until the handshake so that
// address and tag hold steady
`timescale 1ns/1ns
`default_nettype none

module mshr_l2_issue import mshr_pkg::*; (
  input  wire logic      i_clk,
  input  wire logic      i_reset_n,

  input  wire entry_oh_t i_send_ready,
  input  wire paddr_t    i_entry_paddr [MSHR_ENTRIES],
  input  wire logic      i_l2_req_ready,

  output logic           o_l2_req_valid,
  output paddr_t         o_l2_req_paddr,
  output l2_tag_t        o_l2_req_tag,
  output entry_oh_t      o_sent
);

  logic       r_stall;     // Previous cycle valid without ready
  entry_oh_t  r_hold_oh;
  entry_oh_t  w_sel_oh;
  entry_idx_t w_sel_idx;

  assign w_sel_oh  = r_stall ? r_hold_oh : lowest_oh(i_send_ready);
  assign w_sel_idx = oh_to_idx(w_sel_oh);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_stall <= 1'b0;
    end else begin
      r_stall <= o_l2_req_valid & ~i_l2_req_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    r_hold_oh <= w_sel_oh;
  end

  assign o_l2_req_valid = |i_send_ready;
  assign o_l2_req_paddr = i_entry_paddr[w_sel_idx];
  assign o_l2_req_tag   = {L2_TAG_SRC_L1D, {L2_TAG_FILL_W{1'b0}}, w_sel_idx};

  // Entry leaves wait-send on the handshake
  assign o_sent = w_sel_oh & {MSHR_ENTRIES{o_l2_req_valid & i_l2_req_ready}};

endmodule

`default_nettype wire

/* src/mshr_fill_write.sv */
// MSHR fill and L1D write
// Accepts L2 responses meant for the L1D, turns the tag index into a
// fill strobe and resolve notice, then writes completed lines into the
// L1D one at a time, lowest entry first
`timescale 1ns/1ns
`default_nettype none

module mshr_fill_write import mshr_pkg::*; (
  input  wire logic      i_clk,
  input  wire logic      i_reset_n,

  input  wire logic      i_l2_resp_valid,
  input  wire l2_tag_t   i_l2_resp_tag,
  input  wire line_t     i_l2_resp_data,
  input  wire entry_oh_t i_wr_ready,
  input  wire paddr_t    i_entry_paddr [MSHR_ENTRIES],
  input  wire line_t     i_entry_data [MSHR_ENTRIES],
  input  wire logic      i_l1d_wr_ready,

  output entry_oh_t      o_fill,
  output line_t          o_fill_data,
  output logic           o_resolve_valid,
  output entry_oh_t      o_resolve_entry_oh,
  output logic           o_l1d_wr_valid,
  output paddr_t         o_l1d_wr_paddr,
  output line_t          o_l1d_wr_data,
  output entry_oh_t      o_written
);

  // ----------------------------------------
  // L2 response decode
  // ----------------------------------------
  logic w_resp_ok;

  assign w_resp_ok = i_l2_resp_valid & (i_l2_resp_tag[L2_TAG_W-1 -: 2] == L2_TAG_SRC_L1D);

  assign o_fill      = w_resp_ok ? entry_oh_t'(1) << i_l2_resp_tag[ENTRY_IDX_W-1:0] : '0;
  assign o_fill_data = i_l2_resp_data;

  assign o_resolve_valid    = w_resp_ok;  // Same cycle as the fill
  assign o_resolve_entry_oh = o_fill;

  // ----------------------------------------
  // L1D line write
  // ----------------------------------------
  logic       r_stall;
  entry_oh_t  r_hold_oh;
  entry_oh_t  w_sel_oh;
  entry_idx_t w_sel_idx;

  assign w_sel_oh  = r_stall ? r_hold_oh : lowest_oh(i_wr_ready);
  assign w_sel_idx = oh_to_idx(w_sel_oh);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_stall <= 1'b0;
    end else begin
      r_stall <= o_l1d_wr_valid & ~i_l1d_wr_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    r_hold_oh <= w_sel_oh;
  end

  assign o_l1d_wr_valid = |i_wr_ready;
  assign o_l1d_wr_paddr = i_entry_paddr[w_sel_idx];
  assign o_l1d_wr_data  = i_entry_data[w_sel_idx];
  assign o_written      = w_sel_oh & {MSHR_ENTRIES{o_l1d_wr_valid & i_l1d_wr_ready}};

endmodule

`default_nettype wire

/* src/l1d_mshr_top.sv */
// L1D MSHR top level
// Load misses from two LSU ports are merged or allocated, read from L2
// by entry-tagged requests, resolved on the response and written back
// into the L1D. Full and empty come straight from the entry valids
`timescale 1ns/1ns
`default_nettype none

module l1d_mshr_top import mshr_pkg::*; (
  input  wire logic      i_clk,
  input  wire logic      i_reset_n,

  // LSU miss ports
  input  wire port_vec_t i_req_valid,
  input  wire paddr_t    i_req_paddr [NUM_REQ_PORTS],
  output entry_oh_t      o_req_entry_oh [NUM_REQ_PORTS],
  output port_vec_t      o_req_full,

  // L2 read request and response
  output logic           o_l2_req_valid,
  input  wire logic      i_l2_req_ready,
  output paddr_t         o_l2_req_paddr,
  output l2_tag_t        o_l2_req_tag,
  input  wire logic      i_l2_resp_valid,
  input  wire l2_tag_t   i_l2_resp_tag,
  input  wire line_t     i_l2_resp_data,

  output logic           o_resolve_valid,
  output entry_oh_t      o_resolve_entry_oh,

  // L1D line write
  output logic           o_l1d_wr_valid,
  input  wire logic      i_l1d_wr_ready,
  output paddr_t         o_l1d_wr_paddr,
  output line_t          o_l1d_wr_data,

  output logic           o_mshr_full,
  output logic           o_mshr_empty
);

  entry_oh_t w_alloc;
  paddr_t    w_alloc_paddr [MSHR_ENTRIES];
  entry_oh_t w_entry_valid;
  entry_oh_t w_send_ready;
  entry_oh_t w_wr_ready;
  paddr_t    w_entry_paddr [MSHR_ENTRIES];
  line_t     w_entry_data [MSHR_ENTRIES];
  entry_oh_t w_sent;
  entry_oh_t w_fill;
  line_t     w_fill_data;
  entry_oh_t w_written;

  mshr_alloc u_alloc (
    .i_req_valid    (i_req_valid),
    .i_req_paddr    (i_req_paddr),
    .i_entry_valid  (w_entry_valid),
    .i_entry_paddr  (w_entry_paddr),
    .o_req_entry_oh (o_req_entry_oh),
    .o_req_full     (o_req_full),
    .o_alloc        (w_alloc),
    .o_alloc_paddr  (w_alloc_paddr)
  );

  mshr_entry_array u_entries (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_alloc       (w_alloc),
    .i_alloc_paddr (w_alloc_paddr),
    .i_sent        (w_sent),
    .i_fill        (w_fill),
    .i_fill_data   (w_fill_data),
    .i_written     (w_written),
    .o_entry_valid (w_entry_valid),
    .o_send_ready  (w_send_ready),
    .o_wr_ready    (w_wr_ready),
    .o_entry_paddr (w_entry_paddr),
    .o_entry_data  (w_entry_data)
  );

  mshr_l2_issue u_l2_issue (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_send_ready   (w_send_ready),
    .i_entry_paddr  (w_entry_paddr),
    .i_l2_req_ready (i_l2_req_ready),
    .o_l2_req_valid (o_l2_req_valid),
    .o_l2_req_paddr (o_l2_req_paddr),
    .o_l2_req_tag   (o_l2_req_tag),
    .o_sent         (w_sent)
  );

  mshr_fill_write u_fill_write (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_l2_resp_valid    (i_l2_resp_valid),
    .i_l2_resp_tag      (i_l2_resp_tag),
    .i_l2_resp_data     (i_l2_resp_data),
    .i_wr_ready         (w_wr_ready),
    .i_entry_paddr      (w_entry_paddr),
    .i_entry_data       (w_entry_data),
    .i_l1d_wr_ready     (i_l1d_wr_ready),
    .o_fill             (w_fill),
    .o_fill_data        (w_fill_data),
    .o_resolve_valid    (o_resolve_valid),
    .o_resolve_entry_oh (o_resolve_entry_oh),
    .o_l1d_wr_valid     (o_l1d_wr_valid),
    .o_l1d_wr_paddr     (o_l1d_wr_paddr),
    .o_l1d_wr_data      (o_l1d_wr_data),
    .o_written          (w_written)
  );

  // Status for the LSU
  assign o_mshr_full  = &w_entry_valid;
  assign o_mshr_empty = ~|w_entry_valid;

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// Testbench clock and reset
// 10 ns clock, active-low reset held for the first 10 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (10) @(posedge o_clk);
    o_reset_n <= 1'b1;  // Released on an edge
  end

endmodule

`default_nettype wire

/* dv/tb_l1d_mshr.sv */
// L1D MSHR testbench
// Drives the two miss ports, models L2 and the L1D with random ready and
// random response order, tracks which entry holds which line, and checks
// the DUT against that model with concurrent assertions
`timescale 1ns/1ns
`default_nettype none

module tb_l1d_mshr import mshr_pkg::*; ();

  localparam int TEST_CYCLES = 1200;
  localparam int NUM_TESTS   = 6;
  localparam int WAIT_LIMIT  = 1000;

  logic      clk;
  logic      rst_n;
  port_vec_t req_valid;
  paddr_t    req_paddr [NUM_REQ_PORTS];
  entry_oh_t o_req_entry_oh [NUM_REQ_PORTS];
  port_vec_t o_req_full;
  logic      o_l2_req_valid, l2_ready;
  paddr_t    o_l2_req_paddr;
  l2_tag_t   o_l2_req_tag;
  logic      resp_valid;
  l2_tag_t   resp_tag;
  line_t     resp_data;
  logic      o_resolve_valid;
  entry_oh_t o_resolve_entry_oh;
  logic      o_l1d_wr_valid, wr_ready;
  paddr_t    o_l1d_wr_paddr;
  line_t     o_l1d_wr_data;
  logic      o_mshr_full, o_mshr_empty;

  int unsigned err_cnt = 0;
  int unsigned tests_failed = 0;
  logic [31:0] lfsr_state = 32'h9825;
  logic        resp_en = 1'b0;
  int unsigned foreign_cnt = 0;
  int unsigned foreign_done = 0;
  l2_tag_t     q_tag [$];
  paddr_t      q_addr [$];

  tb_clk_gen clk_gen_i (.o_clk(clk), .o_reset_n(rst_n));

  l1d_mshr_top dut_i (
    .i_clk (clk), .i_reset_n (rst_n),
    .i_req_valid (req_valid), .i_req_paddr (req_paddr),
    .o_req_entry_oh (o_req_entry_oh), .o_req_full (o_req_full),
    .o_l2_req_valid (o_l2_req_valid), .i_l2_req_ready (l2_ready),
    .o_l2_req_paddr (o_l2_req_paddr), .o_l2_req_tag (o_l2_req_tag),
    .i_l2_resp_valid (resp_valid), .i_l2_resp_tag (resp_tag), .i_l2_resp_data (resp_data),
    .o_resolve_valid (o_resolve_valid), .o_resolve_entry_oh (o_resolve_entry_oh),
    .o_l1d_wr_valid (o_l1d_wr_valid), .i_l1d_wr_ready (wr_ready),
    .o_l1d_wr_paddr (o_l1d_wr_paddr), .o_l1d_wr_data (o_l1d_wr_data),
    .o_mshr_full (o_mshr_full), .o_mshr_empty (o_mshr_empty)
  );

  // Galois LFSR, one step per bit
  function automatic logic take_bit();
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] take_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  function automatic paddr_t line_of(paddr_t a);
    return {a[PADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
  endfunction

  task automatic flag_error(string msg);
    err_cnt++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // ----------------------------------------
  // L2 and L1D models
  // ----------------------------------------
  initial begin
    logic    l2_hs;
    l2_tag_t hs_tag;
    paddr_t  hs_addr;
    int      k;
    l2_ready   = 1'b0;
    wr_ready   = 1'b0;
    resp_valid = 1'b0;
    resp_tag   = '0;
    resp_data  = '0;
    forever begin
      @(negedge clk);  // Everything settled here
      l2_hs   = rst_n && o_l2_req_valid && l2_ready;
      hs_tag  = o_l2_req_tag;  // The edge moves the issue on to the next entry
      hs_addr = o_l2_req_paddr;
      @(posedge clk);
      #1;
      if (l2_hs) begin
        q_tag.push_back(hs_tag);
        q_addr.push_back(hs_addr);
      end
      l2_ready   = take_bit();
      wr_ready   = take_bit();
      resp_valid = 1'b0;
      if (foreign_cnt != foreign_done) begin
        // Wrong source marker, index of a live request
        resp_valid = 1'b1;
        resp_tag   = {2'b01, 4'b0000, (q_tag.size() > 0) ? q_tag[0][1:0] : 2'b00};
        resp_data  = {4{take_bits(32)}};
        foreign_done++;
      end else if (resp_en && q_tag.size() > 0 && take_bit()) begin
        k = int'(take_bits(2)) % q_tag.size();
        resp_valid = 1'b1;
        resp_tag   = q_tag[k];
        resp_data  = {q_addr[k], ~q_addr[k], q_addr[k] ^ 32'h5a5a_5a5a, take_bits(32)};
        q_tag.delete(k);
        q_addr.delete(k);
      end
    end
  end

  // ----------------------------------------
  // Reference model of the entries
  // ----------------------------------------
  entry_oh_t  tb_busy, tb_sent, tb_filled;
  paddr_t     tb_line [MSHR_ENTRIES];
  line_t      tb_data [MSHR_ENTRIES];
  entry_oh_t  exp_oh [NUM_REQ_PORTS];
  port_vec_t  exp_full, exp_new;
  entry_idx_t exp_idx [NUM_REQ_PORTS];
  entry_idx_t l2_idx, resp_idx, wr_idx;
  logic       port_ok, l2_ok, resp_ok, wr_hit;

  always_comb begin
    entry_oh_t free;
    entry_oh_t hit;
    int        pick;
    free    = ~tb_busy;
    port_ok = 1'b1;
    for (int p = 0; p < NUM_REQ_PORTS; p++) begin
      exp_oh[p]   = '0;
      exp_full[p] = 1'b0;
      exp_new[p]  = 1'b0;
      exp_idx[p]  = '0;
      hit         = '0;
      pick        = 0;
      for (int e = 0; e < MSHR_ENTRIES; e++) begin
        hit[e] = tb_busy[e] && (tb_line[e] == line_of(req_paddr[p]));
      end
      if (!req_valid[p]) begin
        exp_oh[p] = '0;
      end else if (hit != '0) begin
        exp_oh[p] = hit;
      end else if (p > 0 && req_valid[0] && line_of(req_paddr[0]) == line_of(req_paddr[p])) begin
        exp_oh[p]   = exp_oh[0];
        exp_full[p] = exp_full[0];
      end else if (free == '0) begin
        exp_full[p] = 1'b1;
      end else begin
        for (int e = MSHR_ENTRIES - 1; e >= 0; e--) begin
          if (free[e]) pick = e;
        end
        exp_idx[p]       = entry_idx_t'(pick);
        exp_oh[p][pick]  = 1'b1;
        free[pick]       = 1'b0;
        exp_new[p]       = 1'b1;
      end
      if (req_valid[p] && (o_req_entry_oh[p] != exp_oh[p] || o_req_full[p] != exp_full[p])) begin
        port_ok = 1'b0;
      end
    end

    l2_idx  = o_l2_req_tag[ENTRY_IDX_W-1:0];
    l2_ok   = tb_busy[l2_idx] && !tb_sent[l2_idx] && o_l2_req_paddr == tb_line[l2_idx] &&
              o_l2_req_tag[L2_TAG_W-1 -: 2] == L2_TAG_SRC_L1D &&
              o_l2_req_tag[L2_TAG_W-3:ENTRY_IDX_W] == '0;
    resp_idx = resp_tag[ENTRY_IDX_W-1:0];
    resp_ok  = resp_valid && resp_tag[L2_TAG_W-1 -: 2] == L2_TAG_SRC_L1D;
    wr_hit   = 1'b0;
    wr_idx   = '0;
    for (int e = 0; e < MSHR_ENTRIES; e++) begin
      if (tb_busy[e] && tb_line[e] == o_l1d_wr_paddr) begin
        wr_hit = 1'b1;
        wr_idx = entry_idx_t'(e);
      end
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tb_busy   <= '0;
      tb_sent   <= '0;
      tb_filled <= '0;
    end else begin
      for (int p = 0; p < NUM_REQ_PORTS; p++) begin
        if (exp_new[p]) begin
          tb_busy[exp_idx[p]]   <= 1'b1;
          tb_sent[exp_idx[p]]   <= 1'b0;
          tb_filled[exp_idx[p]] <= 1'b0;
          tb_line[exp_idx[p]]   <= line_of(req_paddr[p]);
        end
      end
      if (o_l2_req_valid && l2_ready) tb_sent[l2_idx] <= 1'b1;
      if (resp_ok) begin
        tb_filled[resp_idx] <= 1'b1;
        tb_data[resp_idx]   <= resp_data;
      end
      if (o_l1d_wr_valid && wr_ready && wr_hit) tb_busy[wr_idx] <= 1'b0;
    end
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------
  a_port: assert property (@(posedge clk) disable iff (!rst_n) port_ok)
    else flag_error("port entry one-hot or full differs from model");
  a_l2_req: assert property (@(posedge clk) disable iff (!rst_n)
    o_l2_req_valid && l2_ready |-> l2_ok)
    else flag_error("L2 request with wrong line, tag or duplicate send");
  a_l2_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_l2_req_valid && !l2_ready |=> o_l2_req_valid && $stable(o_l2_req_paddr) &&
    $stable(o_l2_req_tag))
    else flag_error("L2 request changed under back-pressure");
  a_resolve: assert property (@(posedge clk) disable iff (!rst_n)
    o_resolve_valid == resp_ok &&
    (!resp_ok || ($onehot(o_resolve_entry_oh) && o_resolve_entry_oh[resp_idx])))
    else flag_error("resolve pulse does not match accepted response");
  a_wr: assert property (@(posedge clk) disable iff (!rst_n)
    o_l1d_wr_valid |-> wr_hit && tb_filled[wr_idx] && o_l1d_wr_data == tb_data[wr_idx])
    else flag_error("L1D write of wrong line or data");
  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_l1d_wr_valid && !wr_ready |=> o_l1d_wr_valid && $stable(o_l1d_wr_paddr) &&
    $stable(o_l1d_wr_data))
    else flag_error("L1D write changed under back-pressure");
  a_status: assert property (@(posedge clk) disable iff (!rst_n)
    o_mshr_full == (&tb_busy) && o_mshr_empty == (tb_busy == '0))
    else flag_error("full or empty status differs from model");

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  task automatic send_req(logic v0, paddr_t a0, logic v1, paddr_t a1);
    req_valid    = {v1, v0};
    req_paddr[0] = a0;
    req_paddr[1] = a1;
    @(posedge clk);
    #1;
    req_valid = '0;
  endtask

  task automatic wait_empty(string name);
    int n;
    n = 0;
    while (!o_mshr_empty && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!o_mshr_empty) begin
      err_cnt++;
      $display("Timeout in %s: entries were never all freed", name);
    end
  endtask

  task automatic wait_pending(int unsigned cnt, string name);
    int n;
    n = 0;
    while (q_tag.size() < cnt && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (q_tag.size() < cnt) begin
      err_cnt++;
      $display("Timeout in %s: L2 never received the expected reads", name);
    end
  endtask

  task automatic end_test(string name, int unsigned errs_before);
    if (err_cnt == errs_before) begin
      $display("test %-14s pass", name);
    end else begin
      tests_failed++;
      $display("test %-14s fail (%0d errors)", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    #((NUM_TESTS * TEST_CYCLES + 20) * 10);
    $display("Watchdog expired: the run did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int unsigned e0;
    paddr_t      rnd_addr [24];
    req_valid    = '0;
    req_paddr[0] = '0;
    req_paddr[1] = '0;
    for (int i = 0; i < 24; i++) begin
      rnd_addr[i] = take_bits(32);  // Drawn before the models start stepping
    end
    wait (rst_n);
    @(posedge clk);
    #1;

    e0 = err_cnt;  // Single miss
    resp_en = 1'b1;
    send_req(1'b1, 32'h0000_1234, 1'b0, '0);
    wait_empty("single_miss");
    end_test("single_miss", e0);

    e0 = err_cnt;  // Port merge and in-flight merge
    resp_en = 1'b0;
    send_req(1'b1, 32'h0000_2004, 1'b1, 32'h0000_200c);
    send_req(1'b0, '0, 1'b1, 32'h0000_2008);
    send_req(1'b1, 32'h0000_200f, 1'b1, 32'h0000_3000);
    resp_en = 1'b1;
    wait_empty("merge");
    end_test("merge", e0);

    e0 = err_cnt;  // Full, then one free entry left for two ports
    resp_en = 1'b0;
    send_req(1'b1, 32'h0001_0000, 1'b1, 32'h0001_0010);
    send_req(1'b1, 32'h0001_0020, 1'b1, 32'h0001_0030);
    send_req(1'b1, 32'h0001_0040, 1'b0, '0);
    resp_en = 1'b1;
    wait_empty("full");
    resp_en = 1'b0;
    send_req(1'b1, 32'h0002_0000, 1'b1, 32'h0002_0010);
    send_req(1'b1, 32'h0002_0020, 1'b0, '0);
    send_req(1'b1, 32'h0002_0030, 1'b1, 32'h0002_0040);
    resp_en = 1'b1;
    wait_empty("full");
    end_test("full", e0);

    e0 = err_cnt;  // Random ready keeps both paths stalling
    resp_en = 1'b1;
    for (int i = 0; i < 12; i++) begin
      send_req(1'b1, rnd_addr[2 * i], 1'b1, rnd_addr[2 * i + 1]);
    end
    wait_empty("backpressure");
    end_test("backpressure", e0);

    e0 = err_cnt;  // Foreign marker on a live index
    resp_en = 1'b0;
    send_req(1'b1, 32'h0004_0000, 1'b0, '0);
    wait_pending(1, "foreign_tag");
    foreign_cnt++;
    repeat (8) @(posedge clk);
    #1;
    resp_en = 1'b1;
    wait_empty("foreign_tag");
    end_test("foreign_tag", e0);

    e0 = err_cnt;  // All four outstanding, answered in random order
    resp_en = 1'b0;
    send_req(1'b1, 32'h0005_0000, 1'b1, 32'h0005_1000);
    send_req(1'b1, 32'h0005_2000, 1'b1, 32'h0005_3000);
    wait_pending(4, "out_of_order");
    resp_en = 1'b1;
    wait_empty("out_of_order");
    end_test("out_of_order", e0);

    $display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* l1d_mshr_top.f */
src/mshr_pkg.sv
src/mshr_alloc.sv
src/mshr_entry_array.sv
src/mshr_l2_issue.sv
src/mshr_fill_write.sv
src/l1d_mshr_top.sv
dv/tb_clk_gen.sv
dv/tb_l1d_mshr.sv

/* Makefile */
# Verilator build and run of the L1D MSHR testbench

VERILATOR ?= verilator
TOP       ?= tb_l1d_mshr
FILELIST  ?= l1d_mshr_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation result: pass"; \
	else \
	  echo "Simulation result: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
